// ==== src/litex_wrapper_config.svh ====
`ifndef LITEX_WRAPPER_CONFIG_SVH
`define LITEX_WRAPPER_CONFIG_SVH

// Core ports on the wrapper unless the top is overridden
`define LW_NUM_CORES 2

// idbus data width
// Byte addresses on the core side are the same width
`define LW_DATA_W 32

`endif

// ==== src/litex_wrapper_pkg.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

package litex_wrapper_pkg;

    // Access size as issued by a core, RISC-V style encoding
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // Word address plus byte offset within the 32-bit word
    typedef struct packed {
        logic [`LW_DATA_W-3:0] word;
        logic [1:0]            offset;
    } word_byte_t;

    // One byte address seen either whole or split for lane decode
    typedef union packed {
        logic [`LW_DATA_W-1:0] addr;
        word_byte_t            part;
    } byte_addr_t;

endpackage

`default_nettype wire

// ==== src/core_req_arbiter.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module core_req_arbiter #(
    parameter int unsigned NUM_CORES = `LW_NUM_CORES
) (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  logic [NUM_CORES-1:0]                           mem_req,
    input  logic [NUM_CORES-1:0]                           mem_we,
    input  logic [NUM_CORES-1:0][`LW_DATA_W-1:0]           mem_addr,
    input  litex_wrapper_pkg::access_size_t [NUM_CORES-1:0] mem_size,
    input  logic [NUM_CORES-1:0][`LW_DATA_W-1:0]           mem_wdata,
    output logic [NUM_CORES-1:0]                           mem_ack,
    output logic [`LW_DATA_W-1:0]                          mem_rdata,
    output logic                                           mem_err,

    output logic                                           grant_valid,
    output litex_wrapper_pkg::byte_addr_t                  grant_addr,
    output litex_wrapper_pkg::access_size_t                grant_size,
    output logic                                           grant_we,
    output logic [`LW_DATA_W-1:0]                          grant_wdata,

    input  logic                                           done,
    input  logic                                           done_err,
    input  logic [`LW_DATA_W-1:0]                          done_rdata
);

    localparam int unsigned IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [IDX_W-1:0]     ptr;
    logic [IDX_W-1:0]     cur;
    logic                 busy;
    // Served and waiting for req low, doubles as the ack
    logic [NUM_CORES-1:0] served;
    logic [NUM_CORES-1:0] pending;
    logic                 pick_valid;
    logic [IDX_W-1:0]     pick_idx;

    assign pending = mem_req & ~served;
    assign mem_ack = served;

    // Round-robin search starting at ptr, lowest distance wins
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int n = NUM_CORES - 1; n >= 0; n--) begin
            cand = int'(ptr) + n;
            if (cand >= int'(NUM_CORES))
                cand = cand - int'(NUM_CORES);
            if (pending[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr         <= '0;
            cur         <= '0;
            busy        <= 1'b0;
            served      <= '0;
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= 1'b0;
            if (!busy && pick_valid) begin
                grant_valid <= 1'b1;
                busy        <= 1'b1;
                cur         <= pick_idx;
                ptr         <= (pick_idx == IDX_W'(NUM_CORES - 1)) ? '0 : pick_idx + 1'b1;
            end
            // Four-phase release once the core drops req
            for (int k = 0; k < NUM_CORES; k++) begin
                if (served[k] && !mem_req[k])
                    served[k] <= 1'b0;
            end
            if (done) begin
                busy        <= 1'b0;
                served[cur] <= 1'b1;
            end
        end
    end

    // Request fields and response payload
    always_ff @(posedge clk) begin
        if (!busy && pick_valid) begin
            grant_addr  <= mem_addr[pick_idx];
            grant_size  <= mem_size[pick_idx];
            grant_we    <= mem_we[pick_idx];
            grant_wdata <= mem_wdata[pick_idx];
        end
        if (done) begin
            mem_rdata <= done_rdata;
            mem_err   <= done_err;
        end
    end

endmodule

`default_nettype wire

// ==== src/byte_lane_unit.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module byte_lane_unit (
    input  litex_wrapper_pkg::byte_addr_t   grant_addr,
    input  litex_wrapper_pkg::access_size_t grant_size,
    input  logic [`LW_DATA_W-1:0]           grant_wdata,
    input  logic [`LW_DATA_W-1:0]           bus_rdata,

    output logic [`LW_DATA_W-3:0]           word_adr,
    output logic [`LW_DATA_W/8-1:0]         sel,
    output logic [`LW_DATA_W-1:0]           lane_wdata,
    output logic [`LW_DATA_W-1:0]           aligned_rdata,
    output logic                            misaligned
);

    import litex_wrapper_pkg::*;

    localparam int SEL_W = `LW_DATA_W / 8;

    logic [1:0]            offset;
    logic [`LW_DATA_W-1:0] shifted;

    assign word_adr = grant_addr.part.word;
    assign offset   = grant_addr.part.offset;

    // Lane selects, write steering and alignment check
    always_comb begin
        misaligned = 1'b0;
        sel        = '0;
        lane_wdata = grant_wdata;
        case (grant_size)
            SIZE_BYTE: begin
                sel        = SEL_W'(1) << offset;
                lane_wdata = {SEL_W{grant_wdata[7:0]}};
            end
            SIZE_HALF: begin
                sel        = SEL_W'(2'b11) << {offset[1], 1'b0};
                lane_wdata = {(SEL_W / 2){grant_wdata[15:0]}};
                misaligned = offset[0];
            end
            SIZE_WORD: begin
                sel        = '1;
                misaligned = (offset != 2'b00);
            end
            // Encoding 3 has no size behind it
            default: misaligned = 1'b1;
        endcase
    end

    // Read word moved down to bit 0, then zero extended
    assign shifted = bus_rdata >> {offset, 3'b000};

    always_comb begin
        case (grant_size)
            SIZE_BYTE: aligned_rdata = {{(`LW_DATA_W - 8){1'b0}}, shifted[7:0]};
            SIZE_HALF: aligned_rdata = {{(`LW_DATA_W - 16){1'b0}}, shifted[15:0]};
            default:   aligned_rdata = shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/wishbone_master.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module wishbone_master (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         grant_valid,
    input  logic [`LW_DATA_W-3:0]        word_adr,
    input  logic [`LW_DATA_W/8-1:0]      sel,
    input  logic [`LW_DATA_W-1:0]        lane_wdata,
    input  logic                         grant_we,
    input  logic                         misaligned,
    input  logic [`LW_DATA_W-1:0]        aligned_rdata,

    output logic [`LW_DATA_W-3:0]        idbus_adr,
    output logic [`LW_DATA_W-1:0]        idbus_dat_w,
    output logic [`LW_DATA_W/8-1:0]      idbus_sel,
    output logic                         idbus_cyc,
    output logic                         idbus_stb,
    output logic                         idbus_we,
    input  logic                         idbus_ack,
    input  logic                         idbus_err,

    output logic                         done,
    output logic                         done_err,
    output logic [`LW_DATA_W-1:0]        done_rdata
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_BUS     = 2'd1;
    localparam logic [1:0] ST_RESPOND = 2'd2;

    logic [1:0] state;
    logic       bus_end;

    assign bus_end = (state == ST_BUS) && (idbus_ack || idbus_err);
    assign done    = (state == ST_RESPOND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            idbus_cyc <= 1'b0;
            idbus_stb <= 1'b0;
            idbus_we  <= 1'b0;
            done_err  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_valid && misaligned) begin
                        // Never reaches the bus
                        state    <= ST_RESPOND;
                        done_err <= 1'b1;
                    end else if (grant_valid) begin
                        state     <= ST_BUS;
                        idbus_cyc <= 1'b1;
                        idbus_stb <= 1'b1;
                        idbus_we  <= grant_we;
                    end
                end
                ST_BUS: begin
                    // Slave may hold off for as long as it likes
                    if (bus_end) begin
                        state     <= ST_RESPOND;
                        idbus_cyc <= 1'b0;
                        idbus_stb <= 1'b0;
                        idbus_we  <= 1'b0;
                        done_err  <= idbus_err;
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    done_err <= 1'b0;
                end
            endcase
        end
    end

    // Bus address and data, plus captured read data
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && grant_valid) begin
            idbus_adr   <= word_adr;
            idbus_dat_w <= lane_wdata;
            idbus_sel   <= sel;
            done_rdata  <= '0;
        end
        if (bus_end)
            done_rdata <= idbus_err ? '0 : aligned_rdata;
    end

endmodule

`default_nettype wire

// ==== src/litex_wrapper.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module litex_wrapper #(
    parameter int unsigned NUM_CORES = `LW_NUM_CORES
) (
    input  logic                                           clk,
    input  logic                                           rst_n,

    // Core memory ports
    input  logic [NUM_CORES-1:0]                           mem_req,
    input  logic [NUM_CORES-1:0]                           mem_we,
    input  logic [NUM_CORES-1:0][`LW_DATA_W-1:0]           mem_addr,
    input  litex_wrapper_pkg::access_size_t [NUM_CORES-1:0] mem_size,
    input  logic [NUM_CORES-1:0][`LW_DATA_W-1:0]           mem_wdata,
    output logic [NUM_CORES-1:0]                           mem_ack,
    output logic [`LW_DATA_W-1:0]                          mem_rdata,
    output logic                                           mem_err,

    // Shared Wishbone bus
    output logic [`LW_DATA_W-3:0]                          idbus_adr,
    output logic [`LW_DATA_W-1:0]                          idbus_dat_w,
    output logic [`LW_DATA_W/8-1:0]                        idbus_sel,
    output logic                                           idbus_cyc,
    output logic                                           idbus_stb,
    output logic                                           idbus_we,
    input  logic [`LW_DATA_W-1:0]                          idbus_dat_r,
    input  logic                                           idbus_ack,
    input  logic                                           idbus_err
);

    import litex_wrapper_pkg::*;

    logic                    grant_valid;
    byte_addr_t              grant_addr;
    access_size_t            grant_size;
    logic                    grant_we;
    logic [`LW_DATA_W-1:0]   grant_wdata;

    logic [`LW_DATA_W-3:0]   word_adr;
    logic [`LW_DATA_W/8-1:0] sel;
    logic [`LW_DATA_W-1:0]   lane_wdata;
    logic [`LW_DATA_W-1:0]   aligned_rdata;
    logic                    misaligned;

    logic                    done;
    logic                    done_err;
    logic [`LW_DATA_W-1:0]   done_rdata;

    core_req_arbiter #(.NUM_CORES(NUM_CORES)) u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_size   (mem_size),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_err    (mem_err),
        .grant_valid(grant_valid),
        .grant_addr (grant_addr),
        .grant_size (grant_size),
        .grant_we   (grant_we),
        .grant_wdata(grant_wdata),
        .done       (done),
        .done_err   (done_err),
        .done_rdata (done_rdata)
    );

    // Lane decode sits between the held grant and the bus master
    byte_lane_unit u_lanes (
        .grant_addr   (grant_addr),
        .grant_size   (grant_size),
        .grant_wdata  (grant_wdata),
        .bus_rdata    (idbus_dat_r),
        .word_adr     (word_adr),
        .sel          (sel),
        .lane_wdata   (lane_wdata),
        .aligned_rdata(aligned_rdata),
        .misaligned   (misaligned)
    );

    wishbone_master u_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .grant_valid  (grant_valid),
        .word_adr     (word_adr),
        .sel          (sel),
        .lane_wdata   (lane_wdata),
        .grant_we     (grant_we),
        .misaligned   (misaligned),
        .aligned_rdata(aligned_rdata),
        .idbus_adr    (idbus_adr),
        .idbus_dat_w  (idbus_dat_w),
        .idbus_sel    (idbus_sel),
        .idbus_cyc    (idbus_cyc),
        .idbus_stb    (idbus_stb),
        .idbus_we     (idbus_we),
        .idbus_ack    (idbus_ack),
        .idbus_err    (idbus_err),
        .done         (done),
        .done_err     (done_err),
        .done_rdata   (done_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/wb_slave_model.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module wb_slave_model #(
    parameter logic [7:0] ERR_TOP = 8'hF0,
    parameter int         SEED    = 47
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`LW_DATA_W-3:0]   adr,
    input  logic [`LW_DATA_W-1:0]   dat_w,
    input  logic [`LW_DATA_W/8-1:0] sel,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    output logic [`LW_DATA_W-1:0]   dat_r,
    output logic                    ack,
    output logic                    err
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`LW_DATA_W-1:0] mem [256];
    logic [1:0]            delay_left;
    logic                  started;
    logic [7:0]            idx;
    integer                seed;

    // Start-up contents, different in every byte of every word
    function automatic logic [`LW_DATA_W-1:0] fill_word(input logic [7:0] a);
        return {a ^ 8'hA5, ~a, a + 8'h3C, a};
    endfunction

    assign idx = adr[7:0];

    initial begin
        seed  = SEED;
        ack   = 1'b0;
        err   = 1'b0;
        dat_r = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = fill_word(8'(i));
    end

    // One response per bus cycle after a random wait of 0 to 3 cycles
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            err        <= 1'b0;
            started    <= 1'b0;
            delay_left <= '0;
        end else begin
            ack <= 1'b0;
            err <= 1'b0;
            if (cyc && stb && !ack && !err) begin
                if (!started) begin
                    started    <= 1'b1;
                    delay_left <= 2'($random(seed));
                end else if (delay_left != 2'd0) begin
                    delay_left <= delay_left - 2'd1;
                end else begin
                    started <= 1'b0;
                    // Top byte of the byte address picks the error region
                    if (adr[`LW_DATA_W-3 -: 8] == ERR_TOP) begin
                        err <= 1'b1;
                    end else begin
                        ack   <= 1'b1;
                        dat_r <= mem[idx];
                        for (int b = 0; b < `LW_DATA_W / 8; b++) begin
                            if (we && sel[b])
                                mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_litex_wrapper.sv ====
`default_nettype none

`include "litex_wrapper_config.svh"

module tb_litex_wrapper;

    timeunit 1ns;
    timeprecision 1ps;

    import litex_wrapper_pkg::*;

    localparam int         DW              = `LW_DATA_W;
    localparam int         NUM_CORES       = 2;
    localparam int         NUM_REQ         = 200;
    localparam int         CLK_PERIOD      = 4;
    localparam int         RESET_CYCLES    = 8;
    localparam int         WATCHDOG_CYCLES = RESET_CYCLES + 400 * NUM_REQ * NUM_CORES;
    // Slave answers err when the top address byte matches
    localparam logic [7:0] ERR_TOP         = 8'hF0;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic [NUM_CORES-1:0]           mem_req;
    logic [NUM_CORES-1:0]           mem_we;
    logic [NUM_CORES-1:0][DW-1:0]   mem_addr;
    access_size_t [NUM_CORES-1:0]   mem_size;
    logic [NUM_CORES-1:0][DW-1:0]   mem_wdata;
    logic [NUM_CORES-1:0]           mem_ack;
    logic [DW-1:0]                  mem_rdata;
    logic                           mem_err;

    logic [DW-3:0]                  idbus_adr;
    logic [DW-1:0]                  idbus_dat_w;
    logic [DW/8-1:0]                idbus_sel;
    logic                           idbus_cyc;
    logic                           idbus_stb;
    logic                           idbus_we;
    logic [DW-1:0]                  idbus_dat_r;
    logic                           idbus_ack;
    logic                           idbus_err;

    // Per-core traffic, generated before reset is released
    logic [DW-1:0]                  t_addr  [NUM_CORES][NUM_REQ];
    access_size_t                   t_size  [NUM_CORES][NUM_REQ];
    logic                           t_we    [NUM_CORES][NUM_REQ];
    logic [DW-1:0]                  t_wdata [NUM_CORES][NUM_REQ];
    int                             t_gap   [NUM_CORES][NUM_REQ];

    // Reference copy of the slave memory
    logic [DW-1:0]                  model_mem [256];

    integer                         seed;
    int                             cyc_starts  = 0;
    int                             bus_expect  = 0;
    int                             checked     = 0;
    int                             cores_done  = 0;
    int                             cycle_cnt   = 0;
    int                             last_served = -1;
    int                             pend_since [NUM_CORES];
    logic                           cyc_q = 1'b0;
    logic [NUM_CORES-1:0]           ack_q = '0;
    logic [NUM_CORES-1:0]           req_q = '0;
    logic [NUM_CORES-1:0]           pend_q = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    litex_wrapper #(.NUM_CORES(NUM_CORES)) u_litex_wrapper (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_size   (mem_size),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_err    (mem_err),
        .idbus_adr  (idbus_adr),
        .idbus_dat_w(idbus_dat_w),
        .idbus_sel  (idbus_sel),
        .idbus_cyc  (idbus_cyc),
        .idbus_stb  (idbus_stb),
        .idbus_we   (idbus_we),
        .idbus_dat_r(idbus_dat_r),
        .idbus_ack  (idbus_ack),
        .idbus_err  (idbus_err)
    );

    wb_slave_model #(.ERR_TOP(ERR_TOP), .SEED(47)) u_slave (
        .clk  (clk),
        .rst_n(rst_n),
        .adr  (idbus_adr),
        .dat_w(idbus_dat_w),
        .sel  (idbus_sel),
        .cyc  (idbus_cyc),
        .stb  (idbus_stb),
        .we   (idbus_we),
        .dat_r(idbus_dat_r),
        .ack  (idbus_ack),
        .err  (idbus_err)
    );

    // Same start-up contents as the slave memory
    function automatic logic [DW-1:0] fill_word(input logic [7:0] a);
        return {a ^ 8'hA5, ~a, a + 8'h3C, a};
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [DW-1:0] expected,
                                   input logic [DW-1:0] actual);
        fail_run($sformatf("mismatch %s expected %08h actual %08h", test, expected, actual));
    endtask

    // Small word range so reads often hit earlier writes
    task automatic build_traffic();
        logic [7:0] top;
        logic [7:0] idx;
        logic [1:0] off;
        for (int c = 0; c < NUM_CORES; c++) begin
            for (int n = 0; n < NUM_REQ; n++) begin
                top = (($random(seed) & 7) == 0) ? ERR_TOP : 8'h00;
                idx = 8'($random(seed) & 31);
                off = (($random(seed) & 1) == 0) ? 2'($random(seed)) : 2'b00;
                t_addr[c][n]  = {top, 14'h0, idx, off};
                t_size[c][n]  = access_size_t'(2'($unsigned($random(seed)) % 3));
                t_we[c][n]    = 1'($random(seed));
                t_wdata[c][n] = $random(seed);
                t_gap[c][n]   = (($random(seed) & 3) == 0) ? 3 : 0;
            end
        end
    endtask

    // Four-phase requester for one core
    task automatic run_core(input int core);
        for (int n = 0; n < NUM_REQ; n++) begin
            repeat (t_gap[core][n]) @(negedge clk);
            mem_addr[core]  = t_addr[core][n];
            mem_size[core]  = t_size[core][n];
            mem_we[core]    = t_we[core][n];
            mem_wdata[core] = t_wdata[core][n];
            mem_req[core]   = 1'b1;
            while (!mem_ack[core])
                @(negedge clk);
            mem_req[core] = 1'b0;
            while (mem_ack[core])
                @(negedge clk);
        end
        cores_done++;
    endtask

    // Predicts the response from the lane rules and updates the model
    task automatic score_access(input int core);
        logic [DW-1:0] addr;
        logic [DW-1:0] wdata;
        logic [DW-1:0] shifted;
        logic [DW-1:0] exp_rdata;
        logic [7:0]    widx;
        logic [1:0]    off;
        access_size_t  size;
        logic          mis;
        logic          exp_err;
        string         test;
        addr  = mem_addr[core];
        wdata = mem_wdata[core];
        size  = mem_size[core];
        widx  = addr[9:2];
        off   = addr[1:0];
        // Half needs an even offset, word needs offset 0
        mis     = (size == SIZE_HALF && off[0]) || (size == SIZE_WORD && off != 2'b00);
        exp_err = mis || (addr[DW-1 -: 8] == ERR_TOP);
        if (!mis)
            bus_expect++;
        if (mis)
            test = "misaligned";
        else if (exp_err)
            test = "err_region";
        else if (size == SIZE_WORD)
            test = "word_access";
        else
            test = "sub_word_access";
        assert (mem_err == exp_err)
        else report_mismatch({test, " err"}, DW'(exp_err), DW'(mem_err));
        assert (cyc_starts == bus_expect)
        else report_mismatch({test, " bus cycles"}, DW'(bus_expect), DW'(cyc_starts));
        if (!exp_err && mem_we[core]) begin
            case (size)
                SIZE_BYTE: model_mem[widx][int'(off) * 8 +: 8]  = wdata[7:0];
                SIZE_HALF: model_mem[widx][int'(off) * 8 +: 16] = wdata[15:0];
                default:   model_mem[widx]                      = wdata;
            endcase
        end else if (!exp_err) begin
            shifted = model_mem[widx] >> (int'(off) * 8);
            case (size)
                SIZE_BYTE: exp_rdata = {{(DW - 8){1'b0}}, shifted[7:0]};
                SIZE_HALF: exp_rdata = {{(DW - 16){1'b0}}, shifted[15:0]};
                default:   exp_rdata = shifted;
            endcase
            assert (mem_rdata == exp_rdata)
            else report_mismatch({test, " read"}, exp_rdata, mem_rdata);
        end
        checked++;
    endtask

    // Repeat service only if no other core was already waiting when this request appeared
    task automatic check_fairness(input int core);
        for (int j = 0; j < NUM_CORES; j++) begin
            if (j != core && last_served == core && mem_req[j] && !mem_ack[j]) begin
                assert (pend_since[j] > pend_since[core])
                else fail_run($sformatf("core %0d served twice in a row while core %0d waited",
                                        core, j));
            end
        end
        last_served = core;
    endtask

    // Sampled on the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt++;
            if (idbus_cyc && !cyc_q)
                cyc_starts++;
            assert (!(idbus_stb && !idbus_cyc))
            else fail_run("idbus_stb high while idbus_cyc is low");
            assert ($countones(mem_ack) <= 1)
            else fail_run("more than one mem_ack high at once");
            for (int j = 0; j < NUM_CORES; j++) begin
                if (mem_req[j] && !mem_ack[j] && !pend_q[j])
                    pend_since[j] = cycle_cnt;
            end
            for (int i = 0; i < NUM_CORES; i++) begin
                if (mem_ack[i] && !ack_q[i]) begin
                    assert (req_q[i])
                    else fail_run($sformatf("mem_ack of core %0d rose without mem_req", i));
                    score_access(i);
                    check_fairness(i);
                end
                if (!mem_ack[i] && ack_q[i]) begin
                    assert (!req_q[i])
                    else fail_run($sformatf("mem_ack of core %0d fell while mem_req high", i));
                end
            end
        end
        cyc_q  = idbus_cyc;
        ack_q  = mem_ack;
        req_q  = mem_req;
        pend_q = mem_req & ~mem_ack;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        seed      = 47;
        rst_n     = 1'b0;
        mem_req   = '0;
        mem_we    = '0;
        mem_addr  = '0;
        mem_wdata = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            mem_size[c]   = SIZE_WORD;
            pend_since[c] = 0;
        end
        for (int i = 0; i < 256; i++)
            model_mem[i] = fill_word(8'(i));
        build_traffic();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        assert (mem_ack == '0 && !idbus_cyc && !idbus_stb && !idbus_we)
        else fail_run("DUT outputs not idle after reset");
        for (int c = 0; c < NUM_CORES; c++) begin
            automatic int core = c;
            fork
                run_core(core);
            join_none
        end
        wait (cores_done == NUM_CORES);
        repeat (4) @(negedge clk);
        if (checked == NUM_CORES * NUM_REQ) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d accesses were checked",
                               checked, NUM_CORES * NUM_REQ));
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/litex_wrapper_pkg.sv
src/core_req_arbiter.sv
src/byte_lane_unit.sv
src/wishbone_master.sv
src/litex_wrapper.sv
dv/wb_slave_model.sv
dv/tb_litex_wrapper.sv

// ==== Makefile ====
# Verilator build and run for the litex_wrapper testbench

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_litex_wrapper
RTL_TOP    ?= litex_wrapper
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
